// ==== Makefile ====
# Verilator build and run of the execute slice testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f verilog.f --top-module tb_ex_unit \
		-Mdir obj_dir -o sim_ex_unit
	./obj_dir/sim_ex_unit | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hdl/alu.sv ====
/*
 * Integer ALU of the execute stage.
 * Shifts move i_b by i_shamt, never by a register value.
 * slt compares signed. Add and sub wrap without overflow flag.
 */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module alu (
	input  logic [`MIPS_XLEN-1:0]    i_a,
	input  logic [`MIPS_XLEN-1:0]    i_b,
	input  logic [`MIPS_SHAMT_W-1:0] i_shamt,
	input  mips_isa_pkg::alu_ctrl_t  i_ctrl,
	output logic [`MIPS_XLEN-1:0]    o_result,
	output logic                     o_zero
);
	import mips_isa_pkg::*;

	logic less;

	assign less = $signed(i_a) < $signed(i_b);

	// ========================================
	// operation select
	// ========================================
	always_comb begin
		case (i_ctrl)
			alu_ctrl_and: o_result = i_a & i_b;
			alu_ctrl_or:  o_result = i_a | i_b;
			alu_ctrl_nor: o_result = ~(i_a | i_b);
			alu_ctrl_add: o_result = i_a + i_b;
			alu_ctrl_sub: o_result = i_a - i_b;
			alu_ctrl_slt: o_result = {{(`MIPS_XLEN-1){1'b0}}, less};
			alu_ctrl_sll: o_result = i_b << i_shamt;
			alu_ctrl_srl: o_result = i_b >> i_shamt;
			// arithmetic shift keeps the sign of rt
			alu_ctrl_sra: o_result = $unsigned($signed(i_b) >>> i_shamt);
			default:      o_result = '0;
		endcase
	end

	// used by beq
	assign o_zero = (o_result == '0);

endmodule

// ==== hdl/alu_decoder.sv ====
/*
 * Second-level ALU decode from operation class and funct.
 * addu/subu behave as add/sub, no overflow trap exists.
 * Unknown funct codes fall back to add.
 */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module alu_decoder (
	input  mips_isa_pkg::alu_op_t     i_alu_op,
	input  logic [`MIPS_FUNCT_W-1:0]  i_funct,
	output mips_isa_pkg::alu_ctrl_t   o_alu_ctrl
);
	import mips_isa_pkg::*;

	always_comb begin
		case (i_alu_op)
			// address calculation for lw/sw
			alu_op_mem:    o_alu_ctrl = alu_ctrl_add;
			// beq compares by subtracting
			alu_op_branch: o_alu_ctrl = alu_ctrl_sub;
			alu_op_slti:   o_alu_ctrl = alu_ctrl_slt;
			default: begin
				// r-type, look at funct
				case (i_funct)
					funct_add,
					funct_addu: o_alu_ctrl = alu_ctrl_add;
					funct_sub,
					funct_subu: o_alu_ctrl = alu_ctrl_sub;
					funct_and:  o_alu_ctrl = alu_ctrl_and;
					funct_or:   o_alu_ctrl = alu_ctrl_or;
					funct_nor:  o_alu_ctrl = alu_ctrl_nor;
					funct_slt:  o_alu_ctrl = alu_ctrl_slt;
					funct_sll:  o_alu_ctrl = alu_ctrl_sll;
					funct_srl:  o_alu_ctrl = alu_ctrl_srl;
					funct_sra:  o_alu_ctrl = alu_ctrl_sra;
					default:    o_alu_ctrl = alu_ctrl_add;
				endcase
			end
		endcase
	end

endmodule

// ==== hdl/ex_unit_top.sv ====
/*
 * Execute slice top, ID/EX register then execute stage.
 * Two cycle latency, no back-pressure. i_flush turns the incoming
 * word into an all-zero bubble.
 */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module ex_unit_top (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_flush,
	// decoded controls
	input  logic                     i_regdst,
	input  logic                     i_alusrc,
	input  logic [1:0]               i_alu_op,
	input  logic                     i_branch,
	input  logic                     i_memread,
	input  logic                     i_memwrite,
	input  logic                     i_regwrite,
	input  logic                     i_memtoreg,
	// operands from decode
	input  logic [`MIPS_XLEN-1:0]    i_pc4,
	input  logic [`MIPS_XLEN-1:0]    i_rs_data,
	input  logic [`MIPS_XLEN-1:0]    i_rt_data,
	input  logic [`MIPS_XLEN-1:0]    i_imm,
	input  logic [`MIPS_SHAMT_W-1:0] i_shamt,
	input  logic [`MIPS_RA_W-1:0]    i_rt_addr,
	input  logic [`MIPS_RA_W-1:0]    i_rd_addr,
	// EX/MEM contents
	output logic                     o_branch,
	output logic                     o_memread,
	output logic                     o_memwrite,
	output logic                     o_regwrite,
	output logic                     o_memtoreg,
	output logic [`MIPS_XLEN-1:0]    o_branch_target,
	output logic                     o_zero,
	output logic [`MIPS_XLEN-1:0]    o_alu_result,
	output logic [`MIPS_XLEN-1:0]    o_rt_data,
	output logic [`MIPS_RA_W-1:0]    o_wr_addr
);
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	id_ex_t  idex_d;
	id_ex_t  idex_q;
	ex_mem_t exmem;

	// pack decode side ports
	assign idex_d.ex_ctrl.regdst    = i_regdst;
	assign idex_d.ex_ctrl.alusrc    = i_alusrc;
	assign idex_d.ex_ctrl.alu_op    = alu_op_t'(i_alu_op);
	assign idex_d.mem_ctrl.branch   = i_branch;
	assign idex_d.mem_ctrl.memread  = i_memread;
	assign idex_d.mem_ctrl.memwrite = i_memwrite;
	assign idex_d.wb_ctrl.regwrite  = i_regwrite;
	assign idex_d.wb_ctrl.memtoreg  = i_memtoreg;
	assign idex_d.pc4               = i_pc4;
	assign idex_d.rs_data           = i_rs_data;
	assign idex_d.rt_data           = i_rt_data;
	assign idex_d.imm               = i_imm;
	assign idex_d.shamt             = i_shamt;
	assign idex_d.rt_addr           = i_rt_addr;
	assign idex_d.rd_addr           = i_rd_addr;

	pipe_reg #(
		.T         (id_ex_t),
		.BUBBLE_EN (1'b1)
	) u_idex_reg (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_bubble (i_flush),
		.i_d      (idex_d),
		.o_q      (idex_q)
	);

	// ID/EX register drives the source side of the bundle
	id_ex_if u_idex ();

	assign u_idex.ex_ctrl  = idex_q.ex_ctrl;
	assign u_idex.mem_ctrl = idex_q.mem_ctrl;
	assign u_idex.wb_ctrl  = idex_q.wb_ctrl;
	assign u_idex.pc4      = idex_q.pc4;
	assign u_idex.rs_data  = idex_q.rs_data;
	assign u_idex.rt_data  = idex_q.rt_data;
	assign u_idex.imm      = idex_q.imm;
	assign u_idex.shamt    = idex_q.shamt;
	assign u_idex.rt_addr  = idex_q.rt_addr;
	assign u_idex.rd_addr  = idex_q.rd_addr;

	execute u_execute (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_idex  (u_idex.dst),
		.o_exmem (exmem)
	);

	// unpack for the memory stage
	assign o_branch        = exmem.mem_ctrl.branch;
	assign o_memread       = exmem.mem_ctrl.memread;
	assign o_memwrite      = exmem.mem_ctrl.memwrite;
	assign o_regwrite      = exmem.wb_ctrl.regwrite;
	assign o_memtoreg      = exmem.wb_ctrl.memtoreg;
	assign o_branch_target = exmem.branch_target;
	assign o_zero          = exmem.zero;
	assign o_alu_result    = exmem.alu_result;
	assign o_rt_data       = exmem.rt_data;
	assign o_wr_addr       = exmem.wr_addr;

endmodule

// ==== hdl/execute.sv ====
/*
 * Execute stage plus the EX/MEM register behind it.
 * Result appears on o_exmem one clock after the ID/EX word.
 * funct comes from imm[5:0], so decode must sign-extend the full
 * instruction low half for r-type too.
 */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module execute (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	id_ex_if.dst                   i_idex,
	output mips_pipe_pkg::ex_mem_t o_exmem
);
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	logic [`MIPS_XLEN-1:0] branch_target;
	logic [`MIPS_XLEN-1:0] alu_b;
	logic [`MIPS_RA_W-1:0] wr_addr;
	alu_ctrl_t             alu_ctrl;
	logic [`MIPS_XLEN-1:0] alu_result;
	logic                  alu_zero;
	ex_mem_t               exmem_d;

	// ========================================
	// datapath
	// ========================================
	// word offset to byte offset
	assign branch_target = i_idex.pc4 + {i_idex.imm[`MIPS_XLEN-3:0], 2'b00};

	assign alu_b   = i_idex.ex_ctrl.alusrc ? i_idex.imm : i_idex.rt_data;
	// rd for r-type, rt for loads and immediates
	assign wr_addr = i_idex.ex_ctrl.regdst ? i_idex.rd_addr : i_idex.rt_addr;

	alu_decoder u_alu_decoder (
		.i_alu_op   (i_idex.ex_ctrl.alu_op),
		.i_funct    (i_idex.imm[`MIPS_FUNCT_W-1:0]),
		.o_alu_ctrl (alu_ctrl)
	);

	alu u_alu (
		.i_a      (i_idex.rs_data),
		.i_b      (alu_b),
		.i_shamt  (i_idex.shamt),
		.i_ctrl   (alu_ctrl),
		.o_result (alu_result),
		.o_zero   (alu_zero)
	);

	// ========================================
	// EX/MEM register
	// ========================================
	always_comb begin
		exmem_d.mem_ctrl      = i_idex.mem_ctrl;
		exmem_d.wb_ctrl       = i_idex.wb_ctrl;
		exmem_d.branch_target = branch_target;
		exmem_d.zero          = alu_zero;
		exmem_d.alu_result    = alu_result;
		exmem_d.rt_data       = i_idex.rt_data;
		exmem_d.wr_addr       = wr_addr;
	end

	pipe_reg #(
		.T         (ex_mem_t),
		.BUBBLE_EN (1'b0)
	) u_exmem_reg (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_bubble (1'b0),
		.i_d      (exmem_d),
		.o_q      (o_exmem)
	);

	// ========================================
	// checks
	// ========================================
	// an unknown class or funct would quietly decode to add
	a_alu_dec_in_known: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		!$isunknown({i_idex.ex_ctrl.alu_op, i_idex.imm[`MIPS_FUNCT_W-1:0]})
	);

	// a word is either a load or a store, never both
	a_mem_onehot: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		!(i_idex.mem_ctrl.memread && i_idex.mem_ctrl.memwrite)
	);

endmodule

// ==== hdl/id_ex_if.sv ====
/*
 * Registered ID/EX word, one field per signal.
 * No handshake, contents are valid every cycle.
 */
`timescale 1ns/1ps
`include "mips_cfg.svh"

interface id_ex_if ();
	import mips_pipe_pkg::*;

	ex_ctrl_t                 ex_ctrl;
	mem_ctrl_t                mem_ctrl;
	wb_ctrl_t                 wb_ctrl;
	logic [`MIPS_XLEN-1:0]    pc4;
	logic [`MIPS_XLEN-1:0]    rs_data;
	logic [`MIPS_XLEN-1:0]    rt_data;
	logic [`MIPS_XLEN-1:0]    imm;
	logic [`MIPS_SHAMT_W-1:0] shamt;
	logic [`MIPS_RA_W-1:0]    rt_addr;
	logic [`MIPS_RA_W-1:0]    rd_addr;

	// pipeline register side
	modport src (
		output ex_ctrl, mem_ctrl, wb_ctrl, pc4, rs_data, rt_data,
		output imm, shamt, rt_addr, rd_addr
	);

	// execute stage side
	modport dst (
		input ex_ctrl, mem_ctrl, wb_ctrl, pc4, rs_data, rt_data,
		input imm, shamt, rt_addr, rd_addr
	);

endinterface

// ==== hdl/mips_cfg.svh ====
/*
 * Widths for the MIPS execute slice.
 * The funct field is cut from the low bits of the immediate,
 * so MIPS_FUNCT_W must stay below MIPS_XLEN.
 */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

`define MIPS_XLEN    32
`define MIPS_RA_W    5
`define MIPS_SHAMT_W 5
`define MIPS_FUNCT_W 6

`endif

// ==== hdl/mips_isa_pkg.sv ====
/*
 * Encodings seen by the ISA side of the execute stage.
 * Function codes outside funct_e decode to add.
 */
`include "mips_cfg.svh"

package mips_isa_pkg;

	// operation class handed over by the main decoder
	typedef enum logic [1:0] {
		alu_op_mem    = 2'b00,
		alu_op_branch = 2'b01,
		alu_op_rtype  = 2'b10,
		alu_op_slti   = 2'b11
	} alu_op_t;

	// alu control, classic MIPS codes plus the shifts
	typedef enum logic [3:0] {
		alu_ctrl_and = 4'b0000,
		alu_ctrl_or  = 4'b0001,
		alu_ctrl_add = 4'b0010,
		alu_ctrl_sub = 4'b0110,
		alu_ctrl_slt = 4'b0111,
		alu_ctrl_sll = 4'b1000,
		alu_ctrl_srl = 4'b1001,
		alu_ctrl_sra = 4'b1010,
		alu_ctrl_nor = 4'b1100
	} alu_ctrl_t;

	// r-type funct field
	typedef enum logic [`MIPS_FUNCT_W-1:0] {
		funct_sll  = 6'b000000,
		funct_srl  = 6'b000010,
		funct_sra  = 6'b000011,
		funct_add  = 6'b100000,
		funct_addu = 6'b100001,
		funct_sub  = 6'b100010,
		funct_subu = 6'b100011,
		funct_and  = 6'b100100,
		funct_or   = 6'b100101,
		funct_nor  = 6'b100111,
		funct_slt  = 6'b101010
	} funct_e;

endpackage

// ==== hdl/mips_pipe_pkg.sv ====
/*
 * Control groups and stage payloads of the pipeline.
 * An all-zero word is a bubble: no memory access, no register write.
 */
`include "mips_cfg.svh"

package mips_pipe_pkg;

	typedef struct packed {
		logic                  regdst;
		logic                  alusrc;
		mips_isa_pkg::alu_op_t alu_op;
	} ex_ctrl_t;

	typedef struct packed {
		logic branch;
		logic memread;
		logic memwrite;
	} mem_ctrl_t;

	typedef struct packed {
		logic regwrite;
		logic memtoreg;
	} wb_ctrl_t;

	// decode to execute
	typedef struct packed {
		ex_ctrl_t                 ex_ctrl;
		mem_ctrl_t                mem_ctrl;
		wb_ctrl_t                 wb_ctrl;
		logic [`MIPS_XLEN-1:0]    pc4;
		logic [`MIPS_XLEN-1:0]    rs_data;
		logic [`MIPS_XLEN-1:0]    rt_data;
		logic [`MIPS_XLEN-1:0]    imm;
		logic [`MIPS_SHAMT_W-1:0] shamt;
		logic [`MIPS_RA_W-1:0]    rt_addr;
		logic [`MIPS_RA_W-1:0]    rd_addr;
	} id_ex_t;

	// execute to memory
	typedef struct packed {
		mem_ctrl_t             mem_ctrl;
		wb_ctrl_t              wb_ctrl;
		logic [`MIPS_XLEN-1:0] branch_target;
		logic                  zero;
		logic [`MIPS_XLEN-1:0] alu_result;
		logic [`MIPS_XLEN-1:0] rt_data;
		logic [`MIPS_RA_W-1:0] wr_addr;
	} ex_mem_t;

endpackage

// ==== hdl/pipe_reg.sv ====
/*
 * Stage register for any packed payload, cleared by reset.
 * With BUBBLE_EN set, i_bubble loads an all-zero word. That is only a
 * safe bubble when zero means "do nothing" in every control field of T.
 * No stall input, a new word is taken every clock.
 */
`timescale 1ns/1ps

module pipe_reg #(
	parameter type T         = logic,
	parameter bit  BUBBLE_EN = 1'b0
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_bubble,
	input  T     i_d,
	output T     o_q
);

	logic take_bubble;

	// tied low in instances that never insert bubbles
	assign take_bubble = BUBBLE_EN && i_bubble;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_q <= '0;
		end else if (take_bubble) begin
			o_q <= '0;
		end else begin
			o_q <= i_d;
		end
	end

endmodule

// ==== tb/tb_ex_unit.sv ====
/*
 * Testbench for the execute slice, two cycle latency from input to output.
 * A flushed word is all zero in ID/EX, data fields included.
 * Stimulus comes from a fixed-seed xorshift, checks are concurrent assertions.
 */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module tb_ex_unit;
	import mips_pipe_pkg::*;

	logic                     i_clk;
	logic                     i_rst_n;
	logic                     i_flush;
	logic                     i_regdst;
	logic                     i_alusrc;
	logic [1:0]               i_alu_op;
	logic                     i_branch;
	logic                     i_memread;
	logic                     i_memwrite;
	logic                     i_regwrite;
	logic                     i_memtoreg;
	logic [`MIPS_XLEN-1:0]    i_pc4;
	logic [`MIPS_XLEN-1:0]    i_rs_data;
	logic [`MIPS_XLEN-1:0]    i_rt_data;
	logic [`MIPS_XLEN-1:0]    i_imm;
	logic [`MIPS_SHAMT_W-1:0] i_shamt;
	logic [`MIPS_RA_W-1:0]    i_rt_addr;
	logic [`MIPS_RA_W-1:0]    i_rd_addr;
	logic                     o_branch;
	logic                     o_memread;
	logic                     o_memwrite;
	logic                     o_regwrite;
	logic                     o_memtoreg;
	logic [`MIPS_XLEN-1:0]    o_branch_target;
	logic                     o_zero;
	logic [`MIPS_XLEN-1:0]    o_alu_result;
	logic [`MIPS_XLEN-1:0]    o_rt_data;
	logic [`MIPS_RA_W-1:0]    o_wr_addr;

	ex_mem_t     got;
	ex_mem_t     exp_out;
	ex_mem_t     exp_q[$];
	bit          live_q[$];
	logic        tb_live;
	logic [31:0] rng;
	logic [5:0]  rtype_fn [9];
	logic [5:0]  shift_fn [3];
	int          err_count;
	int          n_issued;
	int          n_done;
	int          cyc;

	ex_unit_top dut (.*);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	// ========================================
	// reference model
	// ========================================
	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// word seen by ID/EX at this edge, a flush zeroes all of it
	function automatic id_ex_t capture_word();
		if (i_flush)
			return '0;
		return {i_regdst, i_alusrc, i_alu_op, i_branch, i_memread, i_memwrite,
			i_regwrite, i_memtoreg, i_pc4, i_rs_data, i_rt_data, i_imm,
			i_shamt, i_rt_addr, i_rd_addr};
	endfunction

	function automatic ex_mem_t predict(input id_ex_t w);
		ex_mem_t     e;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [1:0]  op;
		a  = w.rs_data;
		b  = w.ex_ctrl.alusrc ? w.imm : w.rt_data;
		op = w.ex_ctrl.alu_op;
		case (op)
			2'b00: res = a + b;
			2'b01: res = a - b;
			2'b11: res = {31'b0, $signed(a) < $signed(b)};
			default: begin
				case (w.imm[5:0])
					6'h22, 6'h23: res = a - b;
					6'h24: res = a & b;
					6'h25: res = a | b;
					6'h27: res = ~(a | b);
					6'h2a: res = {31'b0, $signed(a) < $signed(b)};
					6'h00: res = b << w.shamt;
					6'h02: res = b >> w.shamt;
					6'h03: begin
						// fill the vacated top bits with the sign of rt
						res = b >> w.shamt;
						if (b[31])
							res = res | ~(32'hffff_ffff >> w.shamt);
					end
					default: res = a + b;
				endcase
			end
		endcase
		e.mem_ctrl      = w.mem_ctrl;
		e.wb_ctrl       = w.wb_ctrl;
		e.branch_target = w.pc4 + (w.imm << 2);
		e.zero          = (res == 32'b0);
		e.alu_result    = res;
		e.rt_data       = w.rt_data;
		e.wr_addr       = w.ex_ctrl.regdst ? w.rd_addr : w.rt_addr;
		return e;
	endfunction

	// exp_out tracks what the outputs should hold after each edge
	always @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			exp_q.delete();
			live_q.delete();
			// the zero word held in ID/EX during reset reaches EX/MEM first
			exp_q.push_back(predict('0));
			live_q.push_back(1'b0);
			exp_out <= '0;
		end else begin
			if (exp_q.size() > 0) begin
				exp_out <= exp_q.pop_front();
				if (live_q.pop_front())
					n_done <= n_done + 1;
			end
			exp_q.push_back(predict(capture_word()));
			live_q.push_back(tb_live);
		end
	end

	always @(posedge i_clk)
		cyc <= cyc + 1;

	// ========================================
	// checks
	// ========================================
	assign got = {o_branch, o_memread, o_memwrite, o_regwrite, o_memtoreg,
		o_branch_target, o_zero, o_alu_result, o_rt_data, o_wr_addr};

	task automatic show_field(input string name, input logic [31:0] exp_v,
		input logic [31:0] got_v);
		err_count++;
		$display("ERR t=%0t %s expected %h got %h", $time, name, exp_v, got_v);
	endtask

	task automatic report_diff(input ex_mem_t e, input ex_mem_t g);
		if (e.mem_ctrl.branch !== g.mem_ctrl.branch)
			show_field("o_branch", 32'(e.mem_ctrl.branch), 32'(g.mem_ctrl.branch));
		if (e.mem_ctrl.memread !== g.mem_ctrl.memread)
			show_field("o_memread", 32'(e.mem_ctrl.memread), 32'(g.mem_ctrl.memread));
		if (e.mem_ctrl.memwrite !== g.mem_ctrl.memwrite)
			show_field("o_memwrite", 32'(e.mem_ctrl.memwrite), 32'(g.mem_ctrl.memwrite));
		if (e.wb_ctrl.regwrite !== g.wb_ctrl.regwrite)
			show_field("o_regwrite", 32'(e.wb_ctrl.regwrite), 32'(g.wb_ctrl.regwrite));
		if (e.wb_ctrl.memtoreg !== g.wb_ctrl.memtoreg)
			show_field("o_memtoreg", 32'(e.wb_ctrl.memtoreg), 32'(g.wb_ctrl.memtoreg));
		if (e.branch_target !== g.branch_target)
			show_field("o_branch_target", e.branch_target, g.branch_target);
		if (e.zero !== g.zero)
			show_field("o_zero", 32'(e.zero), 32'(g.zero));
		if (e.alu_result !== g.alu_result)
			show_field("o_alu_result", e.alu_result, g.alu_result);
		if (e.rt_data !== g.rt_data)
			show_field("o_rt_data", e.rt_data, g.rt_data);
		if (e.wr_addr !== g.wr_addr)
			show_field("o_wr_addr", 32'(e.wr_addr), 32'(g.wr_addr));
	endtask

	a_exmem_match: assert property (@(posedge i_clk) disable iff (!i_rst_n) got == exp_out)
		else report_diff($sampled(exp_out), $sampled(got));

	// skip the first edge, flops may not have seen reset yet
	a_reset_clear: assert property (@(posedge i_clk) (!i_rst_n && cyc > 1) |-> got == '0)
		else begin
			err_count++;
			$display("outputs not all zero while reset is held, t=%0t", $time);
		end

	// ========================================
	// stimulus
	// ========================================
	task automatic issue(input logic [1:0] op, input logic asrc, input logic rdst,
		input logic [5:0] fn, input logic same, input logic flush);
		logic [31:0] r0;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		r0 = next_rand();
		r1 = next_rand();
		r2 = next_rand();
		r3 = next_rand();
		@(posedge i_clk);
		i_flush    <= flush;
		i_regdst   <= rdst;
		i_alusrc   <= asrc;
		i_alu_op   <= op;
		i_branch   <= r0[0];
		i_memread  <= r0[1];
		// never a load and a store at once
		i_memwrite <= r0[2] & ~r0[1];
		i_regwrite <= r0[3];
		i_memtoreg <= r0[4];
		i_pc4      <= {r1[31:2], 2'b00};
		i_rs_data  <= r2;
		i_rt_data  <= same ? r2 : r3;
		i_imm      <= {{16{r0[15]}}, r0[15:6], fn};
		i_shamt    <= r0[20:16];
		i_rt_addr  <= r0[25:21];
		i_rd_addr  <= r0[30:26];
		tb_live    <= 1'b1;
		n_issued++;
	endtask

	initial begin
		int i;
		int k;
		int t;
		bit timed_out;
		timed_out  = 1'b0;
		rng        = 32'd1;
		err_count  = 0;
		n_issued   = 0;
		n_done     = 0;
		cyc        = 0;
		tb_live    = 1'b0;
		i_rst_n    = 1'b0;
		i_flush    = 1'b0;
		i_regdst   = 1'b0;
		i_alusrc   = 1'b0;
		i_alu_op   = 2'b00;
		i_branch   = 1'b0;
		i_memread  = 1'b0;
		i_memwrite = 1'b0;
		i_regwrite = 1'b0;
		i_memtoreg = 1'b0;
		i_pc4      = '0;
		i_rs_data  = '0;
		i_rt_data  = '0;
		i_imm      = '0;
		i_shamt    = '0;
		i_rt_addr  = '0;
		i_rd_addr  = '0;
		rtype_fn   = '{6'h20, 6'h22, 6'h24, 6'h25, 6'h27, 6'h2a, 6'h21, 6'h23, 6'h3f};
		shift_fn   = '{6'h00, 6'h02, 6'h03};

		repeat (16) @(posedge i_clk);
		i_rst_n <= 1'b1;
		// idle zero inputs, outputs start from the reset value
		repeat (3) @(posedge i_clk);

		for (i = 0; i < 9; i++)
			for (k = 0; k < 6; k++)
				issue(2'b10, 1'b0, 1'b1, rtype_fn[i], 1'b0, 1'b0);
		// immediate operand and branch target
		for (k = 0; k < 8; k++) begin
			issue(2'b00, 1'b1, 1'b0, rng[5:0], 1'b0, 1'b0);
			issue(2'b11, 1'b1, 1'b0, rng[5:0], 1'b0, 1'b0);
		end
		// beq with equal and unequal operands
		for (k = 0; k < 6; k++) begin
			issue(2'b01, 1'b0, rng[7], rng[5:0], 1'b1, 1'b0);
			issue(2'b01, 1'b0, rng[7], rng[5:0], 1'b0, 1'b0);
		end
		for (i = 0; i < 3; i++)
			for (k = 0; k < 8; k++)
				issue(2'b10, 1'b0, 1'b1, shift_fn[i], 1'b0, 1'b0);
		// random classes, some of them flushed
		for (k = 0; k < 24; k++)
			issue(rng[9:8], rng[10], rng[11], rng[5:0], 1'b0, rng[12] & rng[13]);

		@(posedge i_clk);
		tb_live <= 1'b0;
		i_flush <= 1'b0;

		for (t = 0; t < 50 && n_done < n_issued; t++)
			@(posedge i_clk);
		if (n_done < n_issued) begin
			$display("timeout, only %0d of %0d results reached the outputs",
				n_done, n_issued);
			timed_out = 1'b1;
		end else begin
			@(posedge i_clk);
			#1;
		end
		$display("end of run: %0d errors, %0d instructions checked", err_count, n_done);
		if (err_count == 0 && !timed_out)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/mips_isa_pkg.sv
hdl/mips_pipe_pkg.sv
hdl/id_ex_if.sv
hdl/pipe_reg.sv
hdl/alu_decoder.sv
hdl/alu.sv
hdl/execute.sv
hdl/ex_unit_top.sv
tb/tb_ex_unit.sv
